/* files.f */
src/cpu_pkg.sv
src/decode_rom.sv
src/timing_unit.sv
src/pc_unit.sv
src/stack_alu_unit.sv
src/bus_matrix.sv
src/cpu_core.sv
tests/cpu_core_tb.sv

/* src/bus_matrix.sv */
// ==============================
// internal buses ADL, ADH, SB and DB with precharge,
// plus the ABL/ABH address registers
// each bus is the AND of its enabled sources
// ==============================

`timescale 1ns/1ps

module bus_matrix import cpu_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_pcl_adl,
    input  logic              i_pch_adh,
    input  logic              i_add_adl,
    input  logic              i_add_sb,
    input  logic              i_zero_adl0,
    input  logic              i_zero_adl1,
    input  logic              i_zero_adh1_7,
    input  logic              i_dl_db,
    input  logic              i_dl_adh,
    input  logic              i_adl_pcl,
    input  logic              i_adh_pch,
    input  logic              i_adl_abl,
    input  logic              i_adh_abh,
    input  logic [DATA_W-1:0] i_pcl,
    input  logic [DATA_W-1:0] i_pch,
    input  logic [DATA_W-1:0] i_s,
    input  logic [DATA_W-1:0] i_add,
    input  logic [DATA_W-1:0] i_data,
    output logic [DATA_W-1:0] o_adl,
    output logic [DATA_W-1:0] o_adh,
    output logic [DATA_W-1:0] o_sb,
    output logic [DATA_W-1:0] o_db,
    output logic [ADDR_W-1:0] o_addr
);

    // each zero line pulls one of the vector's two low bits
    localparam logic [DATA_W-1:0] PULL_ADL0 = VEC_RESET_LO | 8'h02;
    localparam logic [DATA_W-1:0] PULL_ADL1 = VEC_RESET_LO | 8'h01;

    logic [DATA_W-1:0] adl_addr;
    logic [DATA_W-1:0] adh_addr;
    logic [DATA_W-1:0] abl_q;
    logic [DATA_W-1:0] abh_q;

    // phase 1 values, these feed the address registers
    // a PC load from the bus moves its data source to phase 2
    always_comb
    begin
        adl_addr = i_s;
        if (i_pcl_adl)
        begin
            adl_addr = adl_addr & i_pcl;
        end
        if (i_add_adl && !i_adl_pcl)
        begin
            adl_addr = adl_addr & i_add;
        end
        if (i_zero_adl0)
        begin
            adl_addr = adl_addr & PULL_ADL0;
        end
        if (i_zero_adl1)
        begin
            adl_addr = adl_addr & PULL_ADL1;
        end
        adh_addr = BUS_PRECHARGE;
        if (i_pch_adh)
        begin
            adh_addr = adh_addr & i_pch;
        end
        if (i_zero_adh1_7)
        begin
            adh_addr = adh_addr & STACK_PAGE;
        end
    end

    // register load values, phase 2 sources when PC takes the bus
    assign o_adl = i_adl_pcl ? (i_add_adl ? i_add : BUS_PRECHARGE) : adl_addr;
    assign o_adh = i_adh_pch ? (i_dl_adh ? i_data : BUS_PRECHARGE) : adh_addr;
    assign o_sb  = i_add_sb ? i_add : BUS_PRECHARGE;
    assign o_db  = i_dl_db ? i_data : BUS_PRECHARGE;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            abl_q <= '0;
            abh_q <= '0;
        end
        else
        begin
            if (i_adl_abl)
            begin
                abl_q <= adl_addr;
            end
            if (i_adh_abh)
            begin
                abh_q <= adh_addr;
            end
        end
    end

    // new address shows in the same cycle, else the held one
    assign o_addr = {i_adh_abh ? adh_addr : abh_q, i_adl_abl ? adl_addr : abl_q};

endmodule

/* src/cpu_core.sv */
// ==============================
// top level of the core, wiring only
// memory is async read, supplied outside
// ==============================

`timescale 1ns/1ps

module cpu_core
#(
    parameter logic [7:0] SP_RESET = 8'h00
)
(
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic [cpu_pkg::DATA_W-1:0]    i_data,
    output logic [cpu_pkg::ADDR_W-1:0]    o_addr,
    output logic                          o_rw
);

    cpu_pkg::opcode_t opcode;
    cpu_pkg::tcu_t    tcu;
    cpu_pkg::tcu_t    tcu_next;

    // control lines from the decode ROM
    logic pcl_pcl, adl_pcl, i_pc, pcl_adl, pch_pch, adh_pch, pch_adh;
    logic s_adl, sb_s, adl_add, sb_add, db_add, zero_add, sums;
    logic add_adl, add_sb, zero_adl0, zero_adl1, zero_adh1_7;
    logic dl_db, dl_adh, adl_abl, adh_abh;

    logic [cpu_pkg::DATA_W-1:0] pcl, pch, s, add;
    logic [cpu_pkg::DATA_W-1:0] adl, adh, sb, db;

    decode_rom u_decode_rom
    (
        .i_opcode(opcode), .i_tcu(tcu), .o_tcu_next(tcu_next), .o_rw(o_rw),
        .o_pcl_pcl(pcl_pcl), .o_adl_pcl(adl_pcl), .o_i_pc(i_pc),
        .o_pcl_adl(pcl_adl), .o_pch_pch(pch_pch), .o_adh_pch(adh_pch),
        .o_pch_adh(pch_adh), .o_s_adl(s_adl), .o_sb_s(sb_s),
        .o_adl_add(adl_add), .o_sb_add(sb_add), .o_db_add(db_add),
        .o_zero_add(zero_add), .o_sums(sums), .o_add_adl(add_adl),
        .o_add_sb(add_sb), .o_zero_adl0(zero_adl0), .o_zero_adl1(zero_adl1),
        .o_zero_adh1_7(zero_adh1_7), .o_dl_db(dl_db), .o_dl_adh(dl_adh),
        .o_adl_abl(adl_abl), .o_adh_abh(adh_abh)
    );

    timing_unit u_timing_unit
    (
        .i_clk(i_clk), .i_rst(i_rst), .i_data(i_data),
        .i_tcu_next(tcu_next), .o_opcode(opcode), .o_tcu(tcu)
    );

    pc_unit u_pc_unit
    (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_pcl_pcl(pcl_pcl), .i_adl_pcl(adl_pcl),
        .i_pch_pch(pch_pch), .i_adh_pch(adh_pch), .i_i_pc(i_pc),
        .i_adl(adl), .i_adh(adh), .o_pcl(pcl), .o_pch(pch)
    );

    stack_alu_unit #(.SP_RESET(SP_RESET)) u_stack_alu_unit
    (
        .i_clk(i_clk), .i_rst(i_rst), .i_s_adl(s_adl), .i_sb_s(sb_s),
        .i_adl_add(adl_add), .i_sb_add(sb_add), .i_db_add(db_add),
        .i_zero_add(zero_add), .i_sums(sums),
        .i_adl(adl), .i_sb(sb), .i_db(db), .o_s(s), .o_add(add)
    );

    bus_matrix u_bus_matrix
    (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_pcl_adl(pcl_adl), .i_pch_adh(pch_adh), .i_add_adl(add_adl),
        .i_add_sb(add_sb), .i_zero_adl0(zero_adl0), .i_zero_adl1(zero_adl1),
        .i_zero_adh1_7(zero_adh1_7), .i_dl_db(dl_db), .i_dl_adh(dl_adh),
        .i_adl_pcl(adl_pcl), .i_adh_pch(adh_pch),
        .i_adl_abl(adl_abl), .i_adh_abh(adh_abh),
        .i_pcl(pcl), .i_pch(pch), .i_s(s), .i_add(add), .i_data(i_data),
        .o_adl(adl), .o_adh(adh), .o_sb(sb), .o_db(db), .o_addr(o_addr)
    );

endmodule

/* src/cpu_pkg.sv */
// ==============================
// shared types and constants for the 8-bit core
// import into any unit that needs the opcode or cycle
// enums or the bus widths
// ==============================

package cpu_pkg;

    // decoded opcodes, anything else fetched runs as NOP
    typedef enum logic [7:0]
    {
        OP_BRK = 8'h00,
        OP_NOP = 8'hEA
    } opcode_t;

    // timing control unit cycle states
    typedef enum logic [2:0]
    {
        T0, T1, T2, T3, T4, T5, T6, T7
    } tcu_t;

    localparam int DATA_W = 8;
    localparam int ADDR_W = 16;

    // undriven bus lines float high
    localparam logic [DATA_W-1:0] BUS_PRECHARGE = 8'hFF;

    // high address byte for all stack accesses
    localparam logic [DATA_W-1:0] STACK_PAGE = 8'h01;

    // reset vector low byte, high byte is the precharge
    localparam logic [DATA_W-1:0] VEC_RESET_LO = 8'hFC;

endpackage

/* src/decode_rom.sv */
// ==============================
// decode ROM, maps opcode and cycle to the datapath
// control lines and the next cycle value
// purely combinational
// ==============================

`timescale 1ns/1ps

module decode_rom import cpu_pkg::*;
(
    input  opcode_t i_opcode,
    input  tcu_t    i_tcu,
    output tcu_t    o_tcu_next,
    output logic    o_rw,
    output logic    o_pcl_pcl,
    output logic    o_adl_pcl,
    output logic    o_i_pc,
    output logic    o_pcl_adl,
    output logic    o_pch_pch,
    output logic    o_adh_pch,
    output logic    o_pch_adh,
    output logic    o_s_adl,
    output logic    o_sb_s,
    output logic    o_adl_add,
    output logic    o_sb_add,
    output logic    o_db_add,
    output logic    o_zero_add,
    output logic    o_sums,
    output logic    o_add_adl,
    output logic    o_add_sb,
    output logic    o_zero_adl0,
    output logic    o_zero_adl1,
    output logic    o_zero_adh1_7,
    output logic    o_dl_db,
    output logic    o_dl_adh,
    output logic    o_adl_abl,
    output logic    o_adh_abh
);

    always_comb
    begin
        // step to the next cycle unless an entry ends the instruction
        o_tcu_next    = tcu_t'(i_tcu + 3'd1);
        o_rw          = 1'b1;
        o_pcl_pcl     = 1'b0;
        o_adl_pcl     = 1'b0;
        o_i_pc        = 1'b0;
        o_pcl_adl     = 1'b0;
        o_pch_pch     = 1'b0;
        o_adh_pch     = 1'b0;
        o_pch_adh     = 1'b0;
        o_s_adl       = 1'b0;
        o_sb_s        = 1'b0;
        o_adl_add     = 1'b0;
        o_sb_add      = 1'b0;
        o_db_add      = 1'b0;
        o_zero_add    = 1'b0;
        o_sums        = 1'b0;
        o_add_adl     = 1'b0;
        o_add_sb      = 1'b0;
        o_zero_adl0   = 1'b0;
        o_zero_adl1   = 1'b0;
        o_zero_adh1_7 = 1'b0;
        o_dl_db       = 1'b0;
        o_dl_adh      = 1'b0;
        o_adl_abl     = 1'b0;
        o_adh_abh     = 1'b0;

        case (i_tcu)
            T0:
            begin
                // opcode fetch from PC, then step PC
                o_pcl_adl = 1'b1;
                o_pch_adh = 1'b1;
                o_adl_abl = 1'b1;
                o_adh_abh = 1'b1;
                o_pcl_pcl = 1'b1;
                o_pch_pch = 1'b1;
                o_i_pc    = 1'b1;
            end
            T1:
            begin
                // both columns show PC without stepping it
                o_pcl_adl = 1'b1;
                o_pch_adh = 1'b1;
                o_adl_abl = 1'b1;
                o_adh_abh = 1'b1;
                case (i_opcode)
                    OP_BRK:
                    begin
                        o_pcl_pcl = 1'b0;
                    end
                    default:
                    begin
                        o_pcl_pcl  = 1'b1;
                        o_pch_pch  = 1'b1;
                        o_tcu_next = T0;
                    end
                endcase
            end
            T2, T3, T4:
            begin
                case (i_opcode)
                    OP_BRK:
                    begin
                        // stack page on ABH
                        o_zero_adh1_7 = 1'b1;
                        o_adh_abh     = 1'b1;
                        o_adl_abl     = 1'b1;
                        // T2 shows S, later cycles the decremented copy
                        o_s_adl       = (i_tcu == T2);
                        o_add_adl     = (i_tcu != T2);
                        // ADL plus precharged SB is ADL minus one
                        o_adl_add     = 1'b1;
                        o_sb_add      = 1'b1;
                        o_sums        = 1'b1;
                    end
                    default:
                    begin
                        o_tcu_next = T0;
                    end
                endcase
            end
            T5:
            begin
                case (i_opcode)
                    OP_BRK:
                    begin
                        // FFFC, both low lines pulled and ABH left high
                        o_zero_adl0 = 1'b1;
                        o_zero_adl1 = 1'b1;
                        o_adl_abl   = 1'b1;
                        o_adh_abh   = 1'b1;
                        // S minus three via SB, adder is free for the vector
                        o_add_sb    = 1'b1;
                        o_sb_s      = 1'b1;
                        // vector low byte into the adder hold register
                        o_dl_db     = 1'b1;
                        o_db_add    = 1'b1;
                        o_zero_add  = 1'b1;
                        o_sums      = 1'b1;
                    end
                    default:
                    begin
                        o_tcu_next = T0;
                    end
                endcase
            end
            T6:
            begin
                case (i_opcode)
                    OP_BRK:
                    begin
                        // FFFD on the address bus
                        o_zero_adl1 = 1'b1;
                        o_adl_abl   = 1'b1;
                        o_adh_abh   = 1'b1;
                        // phase 2 transfers, vector into PC
                        o_add_adl   = 1'b1;
                        o_adl_pcl   = 1'b1;
                        o_dl_adh    = 1'b1;
                        o_adh_pch   = 1'b1;
                        o_tcu_next  = T0;
                    end
                    default:
                    begin
                        o_tcu_next = T0;
                    end
                endcase
            end
            default:
            begin
                // T7 is never used
                o_tcu_next = T0;
            end
        endcase
    end

endmodule

/* src/pc_unit.sv */
// ==============================
// program counter, PCL and PCH registers
// loads from itself or the ADL/ADH buses, 16-bit increment
// ==============================

`timescale 1ns/1ps

module pc_unit import cpu_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_pcl_pcl,
    input  logic              i_adl_pcl,
    input  logic              i_pch_pch,
    input  logic              i_adh_pch,
    input  logic              i_i_pc,
    input  logic [DATA_W-1:0] i_adl,
    input  logic [DATA_W-1:0] i_adh,
    output logic [DATA_W-1:0] o_pcl,
    output logic [DATA_W-1:0] o_pch
);

    logic [DATA_W-1:0] pcl_q;
    logic [DATA_W-1:0] pch_q;
    logic [DATA_W-1:0] pcl_src;
    logic [DATA_W-1:0] pch_src;
    logic [ADDR_W-1:0] pc_next;

    // bus load wins over recirculation
    assign pcl_src = i_adl_pcl ? i_adl : pcl_q;
    assign pch_src = i_adh_pch ? i_adh : pch_q;

    // carry out of PCL ripples into PCH
    assign pc_next = {pch_src, pcl_src} + ADDR_W'(i_i_pc);

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            pcl_q <= '0;
            pch_q <= '0;
        end
        else
        begin
            if (i_pcl_pcl || i_adl_pcl)
            begin
                pcl_q <= pc_next[DATA_W-1:0];
            end
            if (i_pch_pch || i_adh_pch)
            begin
                pch_q <= pc_next[ADDR_W-1:DATA_W];
            end
        end
    end

    assign o_pcl = pcl_q;
    assign o_pch = pch_q;

endmodule

/* src/stack_alu_unit.sv */
// ==============================
// stack pointer and the adder with its hold register
// S drives ADL only while s_adl is set
// ==============================

`timescale 1ns/1ps

module stack_alu_unit import cpu_pkg::*;
#(
    parameter logic [DATA_W-1:0] SP_RESET = 8'h00
)
(
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_s_adl,
    input  logic              i_sb_s,
    input  logic              i_adl_add,
    input  logic              i_sb_add,
    input  logic              i_db_add,
    input  logic              i_zero_add,
    input  logic              i_sums,
    input  logic [DATA_W-1:0] i_adl,
    input  logic [DATA_W-1:0] i_sb,
    input  logic [DATA_W-1:0] i_db,
    output logic [DATA_W-1:0] o_s,
    output logic [DATA_W-1:0] o_add
);

    logic [DATA_W-1:0] s_q;
    logic [DATA_W-1:0] add_q;
    logic [DATA_W-1:0] a_in;
    logic [DATA_W-1:0] b_in;

    // A input, zero overrides ADL
    always_comb
    begin
        if (i_zero_add)
        begin
            a_in = '0;
        end
        else if (i_adl_add)
        begin
            a_in = i_adl;
        end
        else
        begin
            a_in = BUS_PRECHARGE;
        end
    end

    // B input, open-drain AND of SB and DB
    assign b_in = (i_sb_add ? i_sb : BUS_PRECHARGE) & (i_db_add ? i_db : BUS_PRECHARGE);

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            s_q   <= SP_RESET;
            add_q <= '0;
        end
        else
        begin
            if (i_sb_s)
            begin
                s_q <= i_sb;
            end
            // carry out dropped, FF on B is a decrement
            if (i_sums)
            begin
                add_q <= a_in + b_in;
            end
        end
    end

    assign o_s   = i_s_adl ? s_q : BUS_PRECHARGE;
    assign o_add = add_q;

endmodule

/* src/timing_unit.sv */
// ==============================
// instruction register and cycle counter
// reset enters the BRK sequence at T1
// ==============================

`timescale 1ns/1ps

module timing_unit import cpu_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic [DATA_W-1:0] i_data,
    input  tcu_t              i_tcu_next,
    output opcode_t           o_opcode,
    output tcu_t              o_tcu
);

    opcode_t opcode_q;
    tcu_t    tcu_q;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            opcode_q <= OP_BRK;
            tcu_q    <= T1;
        end
        else
        begin
            tcu_q <= i_tcu_next;
            // opcode byte is on the data bus during T0
            if (tcu_q == T0)
            begin
                opcode_q <= (i_data == OP_BRK) ? OP_BRK : OP_NOP;
            end
        end
    end

    assign o_opcode = opcode_q;
    assign o_tcu    = tcu_q;

endmodule

/* tests/cpu_core_tb.sv */
// ==============================
// testbench for the core with a random NOP/BRK program memory
// a cycle model predicts o_addr and o_rw at every rising edge
// run with the file list, top module cpu_core_tb
// ==============================

`timescale 1ns/1ps

module cpu_core_tb import cpu_pkg::*; ();

    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 16;
    localparam int          RUN_CYCLES   = 2000;
    localparam int          MIN_BRK      = 2;
    localparam int          WATCHDOG_NS  = (RESET_CYCLES + RUN_CYCLES + 100) * CLK_PERIOD;
    localparam logic [31:0] SEED         = 32'ha100_0235;
    localparam logic [7:0]  SP_INIT      = 8'h00;

    logic        i_clk;
    logic        i_rst;
    logic [7:0]  i_data;
    logic [15:0] o_addr;
    logic        o_rw;

    // program memory, async read
    logic [7:0]  mem [0:65535];

    // cycle model state
    logic [15:0] model_pc;
    logic [7:0]  model_sp;
    logic [7:0]  model_vlo;
    logic        model_brk;
    int          model_t;
    logic [15:0] exp_addr;

    int cycle_count = 0;
    int brk_count   = 0;
    int nop_count   = 0;

    cpu_core #(.SP_RESET(SP_INIT)) DUT
    (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .i_data(i_data),
        .o_addr(o_addr),
        .o_rw(o_rw)
    );

    // memory answers in the same cycle, FF while the address is unknown
    assign i_data = $isunknown(o_addr) ? 8'hFF : mem[o_addr];

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    task automatic report_mismatch(input string name, input logic [15:0] exp_val,
                                   input logic [15:0] act_val);
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp_val, act_val);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic fill_memory();
        for (int a = 0; a < 65536; a++)
        begin
            // BRK with one chance in eight, NOP otherwise
            mem[a] = (($urandom % 8) == 0) ? 8'h00 : 8'hEA;
        end
        mem[16'hFFFC] = 8'($urandom);
        mem[16'hFFFD] = 8'($urandom);
    endtask

    // address the core should show in the current cycle
    function automatic logic [15:0] predict_addr();
        case (model_t)
            0, 1:    return model_pc;
            2:       return {8'h01, model_sp};
            3:       return {8'h01, model_sp - 8'd1};
            4:       return {8'h01, model_sp - 8'd2};
            5:       return 16'hFFFC;
            default: return 16'hFFFD;
        endcase
    endfunction

    // state change at the edge that ends the current cycle
    task automatic advance_model();
        case (model_t)
            0:
            begin
                model_brk = (mem[model_pc] == 8'h00);
                if (model_brk)
                begin
                    brk_count++;
                end
                else
                begin
                    nop_count++;
                end
                model_pc = model_pc + 16'd1;
                model_t  = 1;
            end
            1:
            begin
                model_t = model_brk ? 2 : 0;
            end
            4:
            begin
                // three stack slots used, wraps inside page 01
                model_sp = model_sp - 8'd3;
                model_t  = 5;
            end
            5:
            begin
                model_vlo = mem[16'hFFFC];
                model_t   = 6;
            end
            6:
            begin
                model_pc = {mem[16'hFFFD], model_vlo};
                model_t  = 0;
            end
            default:
            begin
                model_t = model_t + 1;
            end
        endcase
    endtask

    always @(posedge i_clk)
    begin
        if (i_rst)
        begin
            // reset enters BRK at T1
            model_pc  = 16'h0000;
            model_sp  = SP_INIT;
            model_vlo = 8'h00;
            model_brk = 1'b1;
            model_t   = 1;
        end
        else
        begin
            exp_addr = predict_addr();
            assert (o_addr === exp_addr)
            else report_mismatch("o_addr", exp_addr, o_addr);
            assert (o_rw === 1'b1)
            else report_mismatch("o_rw", 16'h0001, {15'h0000, o_rw});
            advance_model();
            cycle_count++;
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not end within %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        i_clk = 1'b0;
        i_rst = 1'b1;
        void'($urandom(SEED));
        fill_memory();
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_rst <= 1'b0;
        repeat (RUN_CYCLES) @(posedge i_clk);
        // let the last edge's checks finish
        @(negedge i_clk);
        $display("cycles %0d, BRK %0d, NOP %0d", cycle_count, brk_count, nop_count);
        if (brk_count >= MIN_BRK)
        begin
            $display("RESULT: PASS");
            $finish;
        end
        else
        begin
            $display("Too few BRK instructions were fetched to check the stack sequence");
            $display("RESULT: FAIL");
            $fatal(1, "BRK coverage too low");
        end
    end

endmodule
